/* hdl/tree_cfg_pkg.sv */
// tree shape is fixed here for every router; tree_k must be at least 2 and tree_l at least 2
package tree_cfg_pkg;

    // ========================================
    // tree shape
    // ========================================
    localparam int tree_k = 2;  // children per router, endpoints per leaf
    localparam int tree_l = 3;  // layer 0 = leaves, tree_l-1 = root

    // ========================================
    // derived widths
    // ========================================
    localparam int k_w = (tree_k > 1) ? $clog2(tree_k) : 1;  // one address digit
    localparam int l_w = (tree_l > 1) ? $clog2(tree_l) : 1;  // layer number
    localparam int port_w = $clog2(tree_k + 1);  // ports 0..tree_k, tree_k is up

    // ========================================
    // address and port types
    // ========================================
    // digit i picks the child taken at layer i
    typedef logic [tree_l-1:0][k_w-1:0] addr_t;

    typedef logic [l_w-1:0] level_t;

    typedef logic [port_w-1:0] port_t;  // encoded output port

endpackage

/* hdl/flit_pkg.sv */
// flit layout with a fixed 32 bit payload; the address field follows tree_cfg_pkg
package flit_pkg;

    // ========================================
    // raw flit from the link
    // ========================================
    typedef struct packed {
        logic                head;     // first flit of a packet
        logic                tail;     // last flit, head and tail for single flit
        tree_cfg_pkg::addr_t dest;     // endpoint address, read on head only
        logic [31:0]         payload;
    } flit_t;

    // ========================================
    // route result
    // ========================================
    typedef struct packed {
        tree_cfg_pkg::port_t port;     // output port at this router
        tree_cfg_pkg::port_t lk_port;  // output port at the next router
    } route_t;

    // ========================================
    // flit leaving the port
    // ========================================
    // req has one bit per port except the arrival port
    typedef struct packed {
        flit_t                           flit;
        route_t                          route;
        logic [tree_cfg_pkg::tree_k-1:0] req;
    } routed_flit_t;

endpackage

/* hdl/tree_nca_route.sv */
// level must name a real layer (below tree_l); router digits at or below level are ignored
module tree_nca_route (
    input  tree_cfg_pkg::level_t level,
    input  tree_cfg_pkg::addr_t  router_addr,
    input  tree_cfg_pkg::addr_t  dest,
    output tree_cfg_pkg::port_t  port
);

    logic                        upper_mismatch;  // dest outside this subtree
    logic [tree_cfg_pkg::k_w-1:0] down_digit;

    // ========================================
    // subtree check
    // ========================================
    // digits above the router layer name the subtree the router owns
    always_comb begin
        upper_mismatch = 1'b0;
        for (int i = 0; i < tree_cfg_pkg::tree_l; i++) begin
            if (i > int'(level) && dest[i] != router_addr[i]) begin
                upper_mismatch = 1'b1;
            end
        end
    end

    assign down_digit = dest[level];  // child on the path down

    // ========================================
    // port select
    // ========================================
    // the root has no digits above it, so it never picks the up port
    always_comb begin
        if (upper_mismatch) begin
            port = tree_cfg_pkg::port_t'(tree_cfg_pkg::tree_k);  // up
        end else begin
            port = tree_cfg_pkg::port_t'(down_digit);
        end
    end

endmodule

/* hdl/route_stage.sv */
// body and tail flits reuse the route of the last head; a packet must begin with a head flit
module route_stage #(
    parameter int                  ROUTER_LEVEL = 1,
    parameter tree_cfg_pkg::addr_t ROUTER_POS   = '0
) (
    input  logic             clk,
    input  logic             reset,
    input  flit_pkg::flit_t  in_flit,
    input  logic             in_valid,
    output logic             in_ready,
    output flit_pkg::flit_t  out_flit,
    output flit_pkg::route_t out_route,
    output logic             out_valid,
    input  logic             out_ready
);

    tree_cfg_pkg::port_t  cur_port;
    tree_cfg_pkg::port_t  next_port;
    tree_cfg_pkg::level_t next_level;
    tree_cfg_pkg::addr_t  next_addr;
    logic                 going_up;
    flit_pkg::route_t     head_route;
    flit_pkg::route_t     held_route;  // route of the packet in progress
    flit_pkg::route_t     cur_route;
    logic                 accept;

    // ========================================
    // route at this router
    // ========================================
    tree_nca_route u_cur (
        .level       (tree_cfg_pkg::level_t'(ROUTER_LEVEL)),
        .router_addr (ROUTER_POS),
        .dest        (in_flit.dest),
        .port        (cur_port)
    );

    assign going_up = (cur_port == tree_cfg_pkg::port_t'(tree_cfg_pkg::tree_k));

    // ========================================
    // next router prediction
    // ========================================
    // parent keeps the upper digits, child adds the chosen digit at this layer
    always_comb begin
        next_addr  = ROUTER_POS;
        next_level = tree_cfg_pkg::level_t'(ROUTER_LEVEL);
        if (going_up && ROUTER_LEVEL < tree_cfg_pkg::tree_l - 1) begin
            next_level = tree_cfg_pkg::level_t'(ROUTER_LEVEL + 1);
        end else if (!going_up && ROUTER_LEVEL > 0) begin
            next_level = tree_cfg_pkg::level_t'(ROUTER_LEVEL - 1);
            next_addr[ROUTER_LEVEL] = cur_port[tree_cfg_pkg::k_w-1:0];
        end
    end

    tree_nca_route u_next (
        .level       (next_level),
        .router_addr (next_addr),
        .dest        (in_flit.dest),
        .port        (next_port)
    );

    // a leaf going down hands the flit to an endpoint
    always_comb begin
        head_route.port    = cur_port;
        head_route.lk_port = (ROUTER_LEVEL == 0 && !going_up) ? '0 : next_port;
    end

    assign cur_route = in_flit.head ? head_route : held_route;

    // ========================================
    // stage register
    // ========================================
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid  <= 1'b0;
            held_route <= '0;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;
            end
            if (accept && in_flit.head) begin
                held_route <= head_route;  // kept for body and tail
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_flit  <= in_flit;
            out_route <= cur_route;
        end
    end

endmodule

/* hdl/port_mask_stage.sv */
// IN_PORT must be a port of this router (0..tree_k); the route port is assumed to be in range
module port_mask_stage #(
    parameter int IN_PORT = 0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  flit_pkg::flit_t        in_flit,
    input  flit_pkg::route_t       in_route,
    input  logic                   in_valid,
    output logic                   in_ready,
    output flit_pkg::routed_flit_t out_flit,
    output logic                   out_valid,
    input  logic                   out_ready
);

    localparam int p_all = tree_cfg_pkg::tree_k + 1;

    logic [p_all-1:0]               onehot;  // all ports incl. arrival
    logic [tree_cfg_pkg::tree_k-1:0] req;

    // ========================================
    // decode and strip arrival port
    // ========================================
    always_comb begin
        onehot = '0;
        onehot[in_route.port] = 1'b1;
        for (int i = 0; i < tree_cfg_pkg::tree_k; i++) begin
            req[i] = (i < IN_PORT) ? onehot[i] : onehot[i+1];  // shift above IN_PORT
        end
    end

    // ========================================
    // stage register
    // ========================================
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_flit.flit  <= in_flit;
            out_flit.route <= in_route;
            out_flit.req   <= req;
        end
    end

endmodule

/* hdl/flit_fifo.sv */
// show-ahead FIFO; a write when full or a read when empty is dropped silently
module flit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t wr_data,
    input  logic     wr_en,
    output payload_t rd_data,
    input  logic     rd_en,
    output logic     empty,
    output logic     full
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == cnt_w'(DEPTH));
    assign do_wr   = wr_en && !full;
    assign do_rd   = rd_en && !empty;
    assign rd_data = mem[rd_ptr];  // head visible without a read

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= next_ptr(wr_ptr);
            if (do_rd) rd_ptr <= next_ptr(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

endmodule

/* hdl/credit_sender.sv */
// downstream must never return more credits than DOWN_CREDITS in total outstanding
module credit_sender #(
    parameter int DOWN_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  flit_pkg::routed_flit_t q_data,
    input  logic                   q_empty,
    output logic                   q_pop,
    input  logic                   credit_in,
    output flit_pkg::routed_flit_t flit_out,
    output logic                   flit_out_valid
);

    localparam int cnt_w = $clog2(DOWN_CREDITS + 1);

    logic [cnt_w-1:0] credits;  // free slots downstream
    logic             send;

    // ========================================
    // send gate
    // ========================================
    assign send           = !q_empty && (credits != '0);
    assign q_pop          = send;
    assign flit_out       = q_data;  // queue head straight out
    assign flit_out_valid = send;

    // ========================================
    // credit counter
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= cnt_w'(DOWN_CREDITS);
        end else begin
            case ({send, credit_in})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // send and return cancel
            endcase
        end
    end

endmodule

/* hdl/tree_route_unit.sv */
// one input port; upstream must start with BUF_DEPTH credits and send only while holding one
module tree_route_unit #(
    parameter int                  ROUTER_LEVEL = 1,
    parameter tree_cfg_pkg::addr_t ROUTER_POS   = '0,
    parameter int                  IN_PORT      = 0,
    parameter int                  BUF_DEPTH    = 4,
    parameter int                  DOWN_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  flit_pkg::flit_t        flit_in,
    input  logic                   flit_in_valid,
    output logic                   credit_out,
    output flit_pkg::routed_flit_t flit_out,
    output logic                   flit_out_valid,
    input  logic                   credit_in
);

    flit_pkg::flit_t        in_head;
    logic                   in_empty;
    logic                   in_full;
    logic                   in_pop;
    flit_pkg::flit_t        rs_flit;
    flit_pkg::route_t       rs_route;
    logic                   rs_in_ready;
    logic                   rs_valid;
    logic                   ms_in_ready;
    flit_pkg::routed_flit_t ms_flit;
    logic                   ms_valid;
    flit_pkg::routed_flit_t oq_data;
    logic                   oq_empty;
    logic                   oq_full;
    logic                   oq_pop;

    // ========================================
    // input buffer
    // ========================================
    flit_fifo #(.payload_t(flit_pkg::flit_t), .DEPTH(BUF_DEPTH)) u_in_buf (
        .clk(clk), .reset(reset),
        .wr_data(flit_in), .wr_en(flit_in_valid && !in_full),
        .rd_data(in_head), .rd_en(in_pop),
        .empty(in_empty), .full(in_full)
    );

    assign in_pop     = !in_empty && rs_in_ready;
    assign credit_out = in_pop;  // slot freed upstream

    // ========================================
    // route and mask stages
    // ========================================
    route_stage #(.ROUTER_LEVEL(ROUTER_LEVEL), .ROUTER_POS(ROUTER_POS)) u_route (
        .clk(clk), .reset(reset),
        .in_flit(in_head), .in_valid(!in_empty), .in_ready(rs_in_ready),
        .out_flit(rs_flit), .out_route(rs_route),
        .out_valid(rs_valid), .out_ready(ms_in_ready)
    );

    port_mask_stage #(.IN_PORT(IN_PORT)) u_mask (
        .clk(clk), .reset(reset),
        .in_flit(rs_flit), .in_route(rs_route),
        .in_valid(rs_valid), .in_ready(ms_in_ready),
        .out_flit(ms_flit), .out_valid(ms_valid), .out_ready(!oq_full)
    );

    // ========================================
    // output queue and credit gate
    // ========================================
    flit_fifo #(.payload_t(flit_pkg::routed_flit_t), .DEPTH(BUF_DEPTH)) u_out_q (
        .clk(clk), .reset(reset),
        .wr_data(ms_flit), .wr_en(ms_valid && !oq_full),
        .rd_data(oq_data), .rd_en(oq_pop),
        .empty(oq_empty), .full(oq_full)
    );

    credit_sender #(.DOWN_CREDITS(DOWN_CREDITS)) u_credit (
        .clk(clk), .reset(reset),
        .q_data(oq_data), .q_empty(oq_empty), .q_pop(oq_pop),
        .credit_in(credit_in),
        .flit_out(flit_out), .flit_out_valid(flit_out_valid)
    );

endmodule

/* sim/tb_tree_route_unit.sv */
// expected values assume tree_k 2 and tree_l 3 in tree_cfg_pkg, router on layer 1 under root digit 0
module tb_tree_route_unit;

    // ========================================
    // configuration
    // ========================================
    localparam int                  router_level   = 1;
    localparam tree_cfg_pkg::addr_t router_pos     = 3'b000;  // digit 2 is 0
    localparam int                  in_port        = 0;
    localparam int                  buf_depth      = 4;
    localparam int                  down_credits   = 2;
    localparam int                  reset_cycles   = 8;
    localparam int                  num_random     = 200;
    localparam int                  directed_flits = 21;
    localparam int                  stall_window   = 30;
    localparam int                  max_cycles     =
        reset_cycles + stall_window + 16 * (directed_flits + num_random) + 100;
    localparam tree_cfg_pkg::port_t up_port = tree_cfg_pkg::port_t'(tree_cfg_pkg::tree_k);

    logic                   clk;
    logic                   reset;
    flit_pkg::flit_t        flit_in;
    logic                   flit_in_valid;
    logic                   credit_out;
    flit_pkg::routed_flit_t flit_out;
    logic                   flit_out_valid;
    logic                   credit_in;

    flit_pkg::routed_flit_t exp_q[$];         // expected outputs in send order
    flit_pkg::routed_flit_t exp_entry;
    flit_pkg::route_t       pkt_route;        // route of the packet being sent
    int                     sent_count = 0;
    int                     recv_count = 0;
    int                     credit_out_count = 0;
    int                     ret_count = 0;    // credits handed back downstream
    int                     credit_mode = 1;  // 0 hold, 1 return at once, 2 random
    int                     test_mis = 0;
    int                     mon_mis = 0;
    int                     mon_other = 0;
    int                     cycles;

    tree_route_unit #(
        .ROUTER_LEVEL (router_level),
        .ROUTER_POS   (router_pos),
        .IN_PORT      (in_port),
        .BUF_DEPTH    (buf_depth),
        .DOWN_CREDITS (down_credits)
    ) u_dut (
        .clk            (clk),
        .reset          (reset),
        .flit_in        (flit_in),
        .flit_in_valid  (flit_in_valid),
        .credit_out     (credit_out),
        .flit_out       (flit_out),
        .flit_out_valid (flit_out_valid),
        .credit_in      (credit_in)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================
    // reference route model
    // ========================================
    function automatic tree_cfg_pkg::port_t ref_port(input int lv, input tree_cfg_pkg::addr_t here,
                                                     input tree_cfg_pkg::addr_t dest);
        ref_port = tree_cfg_pkg::port_t'(dest[lv]);  // down by default
        for (int i = lv + 1; i < tree_cfg_pkg::tree_l; i++) begin
            if (dest[i] != here[i]) begin
                ref_port = up_port;
            end
        end
    endfunction

    function automatic flit_pkg::route_t head_route(input tree_cfg_pkg::addr_t dest);
        tree_cfg_pkg::addr_t nxt;
        flit_pkg::route_t    r;
        nxt = router_pos;
        r.port = ref_port(router_level, router_pos, dest);
        if (r.port == up_port) begin
            r.lk_port = ref_port(router_level + 1, router_pos, dest);  // parent
        end else if (router_level == 0) begin
            r.lk_port = '0;  // endpoint next
        end else begin
            nxt[router_level] = r.port[tree_cfg_pkg::k_w-1:0];
            r.lk_port = ref_port(router_level - 1, nxt, dest);
        end
        return r;
    endfunction

    function automatic logic [tree_cfg_pkg::tree_k-1:0] ref_mask(input tree_cfg_pkg::port_t p);
        logic [tree_cfg_pkg::tree_k-1:0] m;
        int                              j;
        m = '0;
        j = 0;
        for (int i = 0; i <= tree_cfg_pkg::tree_k; i++) begin
            if (i != in_port) begin
                if (int'(p) == i) m[j] = 1'b1;
                j++;
            end
        end
        return m;
    endfunction

    // ========================================
    // monitor and downstream model
    // ========================================
    always @(posedge clk) begin
        if (credit_out) begin
            credit_out_count++;
        end
        if (flit_out_valid) begin
            if (recv_count >= exp_q.size()) begin
                $display("ERROR: flit_out_valid high with no flit pending, data %h", flit_out);
                mon_other++;
            end else begin
                exp_entry = exp_q[recv_count];
                if (flit_out.flit !== exp_entry.flit) begin
                    $display("MISMATCH flit_out.flit: got %h expected %h",
                             flit_out.flit, exp_entry.flit);
                    mon_mis++;
                end
                if (flit_out.route.port !== exp_entry.route.port) begin
                    $display("MISMATCH flit_out.route.port: got %h expected %h",
                             flit_out.route.port, exp_entry.route.port);
                    mon_mis++;
                end
                if (flit_out.route.lk_port !== exp_entry.route.lk_port) begin
                    $display("MISMATCH flit_out.route.lk_port: got %h expected %h",
                             flit_out.route.lk_port, exp_entry.route.lk_port);
                    mon_mis++;
                end
                if (flit_out.req !== exp_entry.req) begin
                    $display("MISMATCH flit_out.req: got %h expected %h",
                             flit_out.req, exp_entry.req);
                    mon_mis++;
                end
            end
            recv_count++;
        end
    end

    initial begin
        credit_in = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            credit_in = 1'b0;
            if (credit_mode != 0 && ret_count < recv_count) begin
                if (credit_mode == 1 || $urandom_range(1, 0) == 1) begin
                    credit_in = 1'b1;
                    ret_count++;
                end
            end
        end
    end

    // ========================================
    // drivers
    // ========================================
    task automatic send_flit(input logic head, input logic tail,
                             input tree_cfg_pkg::addr_t dest, input logic [31:0] payload);
        flit_pkg::flit_t        f;
        flit_pkg::routed_flit_t e;
        f.head    = head;
        f.tail    = tail;
        f.dest    = dest;
        f.payload = payload;
        if (head) pkt_route = head_route(dest);  // body and tail follow the head
        e.flit  = f;
        e.route = pkt_route;
        e.req   = ref_mask(pkt_route.port);
        exp_q.push_back(e);
        while (sent_count - credit_out_count >= buf_depth) begin  // no upstream credit
            @(posedge clk);
            #1;
        end
        flit_in       = f;
        flit_in_valid = 1'b1;
        sent_count++;
        @(posedge clk);
        #1;
        flit_in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (recv_count < exp_q.size() || ret_count < recv_count) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_counts();
        $display("summary: %0d flits sent, %0d received, %0d mismatches, %0d other errors",
                 sent_count, recv_count, test_mis + mon_mis, mon_other);
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic test_reset_state();
        repeat (6) begin
            @(posedge clk);
            #1;
            if (flit_out_valid !== 1'b0) begin
                $display("MISMATCH flit_out_valid: got %h expected %h", flit_out_valid, 1'b0);
                test_mis++;
            end
            if (credit_out !== 1'b0) begin
                $display("MISMATCH credit_out: got %h expected %h", credit_out, 1'b0);
                test_mis++;
            end
        end
    endtask

    task automatic test_local_route(input logic go_up);
        tree_cfg_pkg::addr_t dest;
        for (int d = 0; d < 4; d++) begin
            dest = tree_cfg_pkg::addr_t'(d);
            dest[2] = go_up ? ~router_pos[2] : router_pos[2];  // leave or stay in subtree
            send_flit(1'b1, 1'b1, dest, 32'h1000_0000 + 32'(d));
        end
        wait_drain();
    endtask

    task automatic test_multi_flit();
        send_flit(1'b1, 1'b0, tree_cfg_pkg::addr_t'(3'b010), 32'h2000_0001);  // head down
        send_flit(1'b0, 1'b0, tree_cfg_pkg::addr_t'(3'b100), 32'h2000_0002);
        send_flit(1'b0, 1'b1, tree_cfg_pkg::addr_t'(3'b111), 32'h2000_0003);
        send_flit(1'b1, 1'b0, tree_cfg_pkg::addr_t'(3'b101), 32'h2000_0004);  // head up
        send_flit(1'b0, 1'b1, tree_cfg_pkg::addr_t'(3'b010), 32'h2000_0005);
        wait_drain();
    endtask

    task automatic test_credit_stall();
        int recv0;
        int cred0;
        int sent0;
        credit_mode = 0;
        recv0 = recv_count;
        cred0 = credit_out_count;
        sent0 = sent_count;
        for (int i = 0; i < 8; i++) begin
            send_flit(1'b1, 1'b1, tree_cfg_pkg::addr_t'(i), 32'h3000_0000 + 32'(i));
        end
        repeat (stall_window) @(posedge clk);
        #1;
        if (recv_count - recv0 != down_credits) begin
            $display("MISMATCH flit_out_valid count: got %h expected %h",
                     recv_count - recv0, down_credits);
            test_mis++;
        end
        credit_mode = 1;
        wait_drain();
        if (credit_out_count - cred0 != sent_count - sent0) begin
            $display("MISMATCH credit_out count: got %h expected %h",
                     credit_out_count - cred0, sent_count - sent0);
            test_mis++;
        end
    endtask

    task automatic test_random();
        tree_cfg_pkg::addr_t dest;
        credit_mode = 2;
        for (int i = 0; i < num_random; i++) begin
            dest = tree_cfg_pkg::addr_t'($urandom_range((1 << (tree_cfg_pkg::k_w *
                                                                tree_cfg_pkg::tree_l)) - 1, 0));
            send_flit(1'b1, 1'b1, dest, $urandom());
        end
        wait_drain();
        credit_mode = 1;
    endtask

    // ========================================
    // main sequence and timeout
    // ========================================
    initial begin
        void'($urandom(93881));
        reset         = 1'b1;
        flit_in       = '0;
        flit_in_valid = 1'b0;
        pkt_route     = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_local_route(1'b0);  // down
        test_local_route(1'b1);  // up
        test_multi_flit();
        test_credit_stall();
        test_random();
        report_counts();
        if (test_mis + mon_mis + mon_other == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        for (cycles = 0; cycles < max_cycles; cycles++) begin
            @(posedge clk);
        end
        $display("ERROR: timeout, run still busy after %0d cycles", max_cycles);
        report_counts();
        $display("Test failures found");
        $finish;
    end

endmodule

/* compile.f */
hdl/tree_cfg_pkg.sv
hdl/flit_pkg.sv
hdl/tree_nca_route.sv
hdl/route_stage.sv
hdl/port_mask_stage.sv
hdl/flit_fifo.sv
hdl/credit_sender.sv
hdl/tree_route_unit.sv
sim/tb_tree_route_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the route unit testbench with Verilator, pass is judged from the log
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"
verilator --binary --timing -Wno-fatal --top-module tb_tree_route_unit \
    -f compile.f -o sim_tb \
    && ./obj_dir/sim_tb > "$log" 2>&1 \
    || { echo "build or simulation failed"; cat "$log" 2>/dev/null; exit 1; }
cat "$log"
grep -q "All tests passed!" "$log" && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
